// File: uart_pkg.sv
package uart_pkg;

    // 8n1 frame, lsb first.
    localparam int DATA_BITS = 8;

    // baud divisor in clock cycles per bit.
    localparam int DIV_W = 16;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,  // confirming start bit at mid-bit.
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// File: uart_rx_sync.sv
`timescale 1ns/100ps

module uart_rx_sync (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic rx_i,
    output logic rx_sync_o,
    output logic rx_fall_o
);

    logic meta_q;
    logic sync_q;
    logic prev_q;

    // line idles high, so reset high avoids a false edge.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            meta_q <= 1'b1;
            sync_q <= 1'b1;
            prev_q <= 1'b1;
        end else begin
            meta_q <= rx_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign rx_sync_o = sync_q;
    assign rx_fall_o = prev_q & ~sync_q;  // first low after high.

endmodule

// File: uart_rx.sv
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 rx_sync_i,
    input  logic                 rx_fall_i,
    input  logic [DIV_W-1:0]     baud_div_i,
    output logic [DATA_BITS-1:0] byte_o,
    output logic                 byte_valid_o,
    output logic                 frame_err_o
);

    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(DATA_BITS - 1);

    rx_state_e            state_q;
    logic [DIV_W-1:0]     cnt_q;
    logic [IDX_W-1:0]     bit_idx_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 tick;

    assign tick   = (cnt_q == '0);
    assign byte_o = shift_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= RX_IDLE;
            cnt_q        <= '0;
            bit_idx_q    <= '0;
            byte_valid_o <= 1'b0;
            frame_err_o  <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            frame_err_o  <= 1'b0;
            if (!tick) begin
                cnt_q <= cnt_q - 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    if (rx_fall_i) begin
                        cnt_q   <= (baud_div_i >> 1) - 1'b1;  // half a bit.
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (rx_sync_i) begin
                            state_q <= RX_IDLE;  // glitch, not a start bit.
                        end else begin
                            cnt_q     <= baud_div_i - 1'b1;
                            bit_idx_q <= '0;
                            state_q   <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        cnt_q <= baud_div_i - 1'b1;
                        if (bit_idx_q == LAST_BIT) begin
                            state_q <= RX_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        byte_valid_o <= rx_sync_i;
                        frame_err_o  <= ~rx_sync_i;  // stop bit must be high.
                        state_q      <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top.
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && tick) begin
            shift_q <= {rx_sync_i, shift_q[DATA_BITS-1:1]};
        end
    end

    // divisor comes from outside, so hold it to the minimum over a frame.
    a_div_min: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (state_q != RX_IDLE) |-> (baud_div_i >= DIV_W'(4))
    ) else $error("uart_rx: baud_div_i below 4 during a frame");

endmodule

// File: uart_rx_fifo.sv
`timescale 1ns/100ps

module uart_rx_fifo import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 push_i,
    input  logic [DATA_BITS-1:0] push_data_i,
    input  logic                 pop_i,
    output logic [DATA_BITS-1:0] rd_data_o,
    output logic                 rd_valid_o,
    output logic                 overflow_o
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(FIFO_DEPTH);

    logic [DATA_BITS-1:0] mem_q [FIFO_DEPTH];
    logic [AW-1:0]        rd_ptr_q;
    logic [AW-1:0]        wr_ptr_q;
    logic [AW:0]          count_q;
    logic                 pop_ok;
    logic                 push_ok;

    assign pop_ok  = pop_i && (count_q != '0);
    assign push_ok = push_i && ((count_q != FULL_CNT) || pop_ok);  // full + pop frees a slot.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
            if (push_i && !push_ok) begin
                overflow_o <= 1'b1;  // sticky until reset.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign rd_data_o  = mem_q[rd_ptr_q];  // show-ahead head entry.
    assign rd_valid_o = (count_q != '0);

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        count_q <= FULL_CNT
    ) else $error("uart_rx_fifo: count above FIFO_DEPTH");

endmodule

// File: uart_tx.sv
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 start_i,
    input  logic [DATA_BITS-1:0] data_i,
    input  logic [DIV_W-1:0]     baud_div_i,
    output logic                 tx_o,
    output logic                 ready_o
);

    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(DATA_BITS - 1);

    tx_state_e            state_q;
    logic [DIV_W-1:0]     cnt_q;
    logic [IDX_W-1:0]     bit_idx_q;
    logic [DATA_BITS-1:0] data_q;
    logic                 tick;

    assign tick    = (cnt_q == '0);
    assign ready_o = (state_q == TX_IDLE);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_o      <= 1'b1;
        end else begin
            if (!tick) begin
                cnt_q <= cnt_q - 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        cnt_q   <= baud_div_i - 1'b1;
                        tx_o    <= 1'b0;  // start bit.
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        cnt_q     <= baud_div_i - 1'b1;
                        bit_idx_q <= '0;
                        tx_o      <= data_q[0];
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        cnt_q <= baud_div_i - 1'b1;
                        if (bit_idx_q == LAST_BIT) begin
                            tx_o    <= 1'b1;  // stop bit.
                            state_q <= TX_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_o      <= data_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // latch on accept, then shift one bit out per bit time.
    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && start_i) begin
            data_q <= data_i;
        end else if (state_q == TX_DATA && tick) begin
            data_q <= data_q >> 1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ready_o |-> tx_o
    ) else $error("uart_tx: line low while ready");

endmodule

// File: uart_top.sv
`timescale 1ns/100ps

module uart_top import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic [DIV_W-1:0]     baud_div_i,
    input  logic                 rx_i,
    input  logic                 rx_pop_i,
    input  logic [DATA_BITS-1:0] tx_data_i,
    input  logic                 tx_start_i,
    output logic [DATA_BITS-1:0] rx_data_o,
    output logic                 rx_valid_o,
    output logic                 rx_overflow_o,
    output logic                 rx_frame_err_o,
    output logic                 tx_o,
    output logic                 tx_ready_o
);

    logic                 rx_sync;
    logic                 rx_fall;
    logic [DATA_BITS-1:0] rx_byte;
    logic                 rx_byte_valid;

    uart_rx_sync i_uart_rx_sync (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rx_i      (rx_i),
        .rx_sync_o (rx_sync),
        .rx_fall_o (rx_fall)
    );

    uart_rx i_uart_rx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rx_sync_i    (rx_sync),
        .rx_fall_i    (rx_fall),
        .baud_div_i   (baud_div_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid),
        .frame_err_o  (rx_frame_err_o)
    );

    uart_rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_uart_rx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (rx_byte_valid),
        .push_data_i (rx_byte),
        .pop_i       (rx_pop_i),
        .rd_data_o   (rx_data_o),
        .rd_valid_o  (rx_valid_o),
        .overflow_o  (rx_overflow_o)
    );

    uart_tx i_uart_tx (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (tx_start_i),
        .data_i     (tx_data_i),
        .baud_div_i (baud_div_i),
        .tx_o       (tx_o),
        .ready_o    (tx_ready_o)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;  // release between edges.
    end

    always #20 clk_o = ~clk_o;  // 40 ns period.

endmodule

// File: tb_uart.sv
`timescale 1ns/100ps

module tb_uart;

    localparam int BIT_CYC    = 8;
    localparam int FRAME_CYC  = 10 * BIT_CYC;
    localparam int NUM_FRAMES = 60;
    localparam int MAX_CYCLES = 4 * NUM_FRAMES * FRAME_CYC + 800;  // about 4x the test length.
    localparam int DEPTH      = 4;

    logic        clk;
    logic        rstn;
    logic [15:0] baud_div;
    logic        rx_drv;
    logic        loop_en;
    logic        rx_line;
    logic        rx_pop;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_overflow;
    logic        rx_frame_err;
    logic        tx;
    logic        tx_ready;

    logic [31:0] seed = 32'd56;
    logic [7:0]  model_q[$];
    logic        exp_ovf = 1'b0;
    int          ferr_cnt = 0;
    int          cycles = 0;
    int          test_errs = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    assign rx_line = loop_en ? tx : rx_drv;  // loopback mux.

    tb_clk_gen i_tb_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    uart_top #(
        .FIFO_DEPTH (DEPTH)
    ) i_uart_top (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .baud_div_i     (baud_div),
        .rx_i           (rx_line),
        .rx_pop_i       (rx_pop),
        .tx_data_i      (tx_data),
        .tx_start_i     (tx_start),
        .rx_data_o      (rx_data),
        .rx_valid_o     (rx_valid),
        .rx_overflow_o  (rx_overflow),
        .rx_frame_err_o (rx_frame_err),
        .tx_o           (tx),
        .tx_ready_o     (tx_ready)
    );

    always @(negedge clk) begin
        if (rstn && rx_frame_err) begin
            ferr_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [7:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];  // upper bits, better period.
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %0d ns %s expected %0h actual %0h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_fail(input string what);
        $display("%0d ns: %s", $time, what);
        test_errs++;
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
        if (test_errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        err_cnt  += test_errs;
        test_errs = 0;
    endtask

    // full fifo drops the byte.
    task automatic model_push(input logic [7:0] b);
        if (model_q.size() < DEPTH) begin
            model_q.push_back(b);
        end else begin
            exp_ovf = 1'b1;
        end
    endtask

    // one 8n1 frame on rx, called at a falling edge.
    task automatic send_serial(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_drv = frame[i];
            repeat (BIT_CYC) @(negedge clk);
        end
        rx_drv = 1'b1;
    endtask

    task automatic wait_rx_valid(output logic ok);
        int n;
        n = 0;
        while (rx_valid !== 1'b1 && n < 2 * FRAME_CYC) begin
            @(negedge clk);
            n++;
        end
        ok = (rx_valid === 1'b1);
    endtask

    task automatic pop_and_check();
        logic       ok;
        logic [7:0] exp;
        exp = model_q.pop_front();
        wait_rx_valid(ok);
        if (!ok) begin
            report_fail("rx_valid_o did not rise for an expected byte");
        end else begin
            check_value("rx_data_o", exp, rx_data);
            rx_pop = 1'b1;
            @(negedge clk);
            rx_pop = 1'b0;
        end
    endtask

    task automatic start_tx(input logic [7:0] b);
        int n;
        n = 0;
        while (tx_ready !== 1'b1 && n < 2 * FRAME_CYC) begin
            @(negedge clk);
            n++;
        end
        if (tx_ready !== 1'b1) begin
            report_fail("tx_ready_o stayed low, transmitter never went idle");
        end
        tx_data  = b;
        tx_start = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
    endtask

    // samples tx_o at each mid-bit.
    task automatic decode_tx(output logic [7:0] b, output logic stop);
        int n;
        n = 0;
        while (tx !== 1'b0 && n < FRAME_CYC) begin
            @(negedge clk);
            n++;
        end
        repeat (BIT_CYC / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            report_fail("tx_o start bit not low at mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            b[i] = tx;
        end
        repeat (BIT_CYC) @(negedge clk);
        stop = tx;
    endtask

    initial begin : main_seq
        logic [7:0] b;
        logic [7:0] got;
        logic       stop;
        logic       valid_seen;
        int         fe_start;
        baud_div = 16'(BIT_CYC);
        rx_drv   = 1'b1;
        loop_en  = 1'b0;
        rx_pop   = 1'b0;
        tx_data  = 8'h00;
        tx_start = 1'b0;
        @(posedge rstn);
        @(negedge clk);

        check_value("tx_o", 1, tx);
        check_value("tx_ready_o", 1, tx_ready);
        check_value("rx_valid_o", 0, rx_valid);
        check_value("rx_overflow_o", 0, rx_overflow);
        check_value("rx_frame_err_o", 0, rx_frame_err);
        end_test("reset");

        for (int i = 0; i < 20; i++) begin
            b = next_rand();
            start_tx(b);
            decode_tx(got, stop);
            check_value("tx_o data", b, got);
            check_value("tx_o stop bit", 1, stop);
        end
        end_test("transmit");

        for (int i = 0; i < 20; i++) begin
            b = next_rand();
            model_push(b);
            send_serial(b, 1'b0);
            pop_and_check();
        end
        end_test("receive");

        fe_start   = ferr_cnt;
        valid_seen = 1'b0;
        send_serial(next_rand(), 1'b1);
        repeat (BIT_CYC) begin
            @(negedge clk);
            valid_seen = valid_seen | rx_valid;
        end
        check_value("rx_frame_err_o pulses", fe_start + 1, ferr_cnt);
        if (valid_seen !== 1'b0) begin
            report_fail("rx_valid_o rose after a frame with a low stop bit");
        end
        b = next_rand();
        model_push(b);
        send_serial(b, 1'b0);
        pop_and_check();
        end_test("frame_err");

        for (int i = 0; i < DEPTH + 1; i++) begin
            b = next_rand();
            model_push(b);
            send_serial(b, 1'b0);
        end
        repeat (BIT_CYC) @(negedge clk);
        check_value("rx_overflow_o", exp_ovf, rx_overflow);
        while (model_q.size() != 0) begin
            pop_and_check();
        end
        check_value("rx_valid_o", 0, rx_valid);
        end_test("overflow");

        loop_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            b = next_rand();
            model_push(b);
            start_tx(b);
            pop_and_check();
        end
        check_value("rx_overflow_o", exp_ovf, rx_overflow);  // still sticky.
        end_test("loopback");

        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
uart_pkg.sv
uart_rx_sync.sv
uart_rx.sv
uart_rx_fifo.sv
uart_tx.sv
uart_top.sv
tb_clk_gen.sv
tb_uart.sv

// File: Bender.yml
package:
  name: uart

sources:
  - uart_pkg.sv
  - uart_rx_sync.sv
  - uart_rx.sv
  - uart_rx_fifo.sv
  - uart_tx.sv
  - uart_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_uart.sv
